// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wall
TOP       ?= tb_top_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/rv_core_pkg.sv ====
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [31:0] RESET_PC      = 32'h8000_0000;
    localparam logic [31:0] TRAP_VEC      = 32'h8000_0100;
    localparam logic [31:0] MTIMECMP_ADDR = 32'hF000_0000;

    localparam logic [31:0] NOP_INSTR       = 32'h0000_0013; // addi x0, x0, 0
    localparam logic [31:0] TRAP_LINK_INSTR = 32'h0000_0f97; // auipc x31, 0
    localparam logic [31:0] WFI_INSTR       = 32'h1050_0073;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_WB,
        S_WFI,
        S_TRAP,
        S_HALT
    } core_state_t;

    typedef enum logic [2:0] {
        C_ALU,
        C_LOAD,
        C_STORE,
        C_JUMP,
        C_BRANCH,
        C_WFI,
        C_ECALL
    } instr_class_t;

endpackage

// ==== core/core_ctrl.sv ====
module core_ctrl (
    input  logic        CLK,
    input  logic        arst_n,
    input  logic        busy,
    input  logic        error,
    input  logic [31:0] rdata,
    output logic        ren,
    output logic        wen,
    output logic [31:0] addr,
    output logic [31:0] wdata,
    output logic [3:0]  byte_en,
    output logic [31:0] instr,
    output logic [31:0] pc,
    input  rv_core_pkg::instr_class_t iclass,
    input  logic [31:0] wb_value,
    input  logic [31:0] next_pc,
    input  logic [31:0] mem_addr,
    input  logic [31:0] store_data,
    input  logic [3:0]  store_lanes,
    output logic [31:0] load_data,
    output logic        rf_we,
    input  logic        irq_pending,
    output logic        irq_ack,
    output logic        mtimecmp_we,
    output logic        wfi,
    output logic        halt
);

    rv_core_pkg::core_state_t state, after_retire;
    logic [31:0] ir;
    logic        timer_store;
    logic        data_phase;

    assign timer_store = (iclass == rv_core_pkg::C_STORE) &&
                         (mem_addr == rv_core_pkg::MTIMECMP_ADDR);
    assign after_retire = irq_pending ? rv_core_pkg::S_TRAP : rv_core_pkg::S_FETCH;
    assign data_phase = (state == rv_core_pkg::S_MEM);

    // Trap cycle runs auipc x31, 0 through the datapath to save the return pc
    assign instr = (state == rv_core_pkg::S_TRAP) ? rv_core_pkg::TRAP_LINK_INSTR : ir;

    assign ren = (state == rv_core_pkg::S_FETCH) ||
                 (data_phase && iclass == rv_core_pkg::C_LOAD);
    assign wen = data_phase && (iclass == rv_core_pkg::C_STORE);
    assign addr    = data_phase ? mem_addr : pc;
    assign byte_en = data_phase ? store_lanes : 4'hf;
    assign wdata   = store_data;

    assign rf_we = (state == rv_core_pkg::S_EXEC &&
                    (iclass == rv_core_pkg::C_ALU || iclass == rv_core_pkg::C_JUMP)) ||
                   (state == rv_core_pkg::S_WB && iclass == rv_core_pkg::C_LOAD) ||
                   (state == rv_core_pkg::S_TRAP);
    assign mtimecmp_we = (state == rv_core_pkg::S_EXEC) && timer_store;
    assign irq_ack = (state == rv_core_pkg::S_TRAP);
    assign wfi     = (state == rv_core_pkg::S_WFI);
    assign halt    = (state == rv_core_pkg::S_HALT);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state <= rv_core_pkg::S_WB; // Leaves WB on the first edge into fetch
            pc    <= rv_core_pkg::RESET_PC;
            ir    <= rv_core_pkg::NOP_INSTR;
        end else begin
            case (state)
                rv_core_pkg::S_FETCH: begin
                    if (!busy) begin
                        ir    <= rdata;
                        state <= error ? rv_core_pkg::S_HALT : rv_core_pkg::S_EXEC;
                    end
                end
                rv_core_pkg::S_EXEC: begin
                    pc <= next_pc;
                    case (iclass)
                        rv_core_pkg::C_LOAD:  state <= rv_core_pkg::S_MEM;
                        rv_core_pkg::C_STORE: state <= timer_store ? after_retire
                                                                   : rv_core_pkg::S_MEM;
                        rv_core_pkg::C_WFI:   state <= rv_core_pkg::S_WFI;
                        rv_core_pkg::C_ECALL: state <= rv_core_pkg::S_HALT;
                        default:              state <= after_retire;
                    endcase
                end
                rv_core_pkg::S_MEM: begin
                    if (!busy) begin
                        state <= error ? rv_core_pkg::S_HALT : rv_core_pkg::S_WB;
                    end
                end
                rv_core_pkg::S_WB: state <= after_retire;
                rv_core_pkg::S_WFI: begin
                    if (irq_pending) begin
                        state <= rv_core_pkg::S_TRAP;
                    end
                end
                rv_core_pkg::S_TRAP: begin
                    pc    <= rv_core_pkg::TRAP_VEC;
                    state <= rv_core_pkg::S_FETCH;
                end
                default: state <= rv_core_pkg::S_HALT;
            endcase
        end
    end

    // Load word captured on the completing edge
    always_ff @(posedge CLK) begin
        if (data_phase && !busy) begin
            load_data <= rdata;
        end
    end

    a_one_request: assert property (@(posedge CLK) disable iff (!arst_n)
        !(ren && wen));

    a_hold_on_busy: assert property (@(posedge CLK) disable iff (!arst_n)
        (ren || wen) && busy |=> $stable(addr) && $stable(byte_en) && $stable(wdata));

endmodule

// ==== core/exec_unit.sv ====
module exec_unit (
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    input  logic [31:0] load_data,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs1,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rd,
    output rv_core_pkg::instr_class_t iclass,
    output logic [31:0] wb_value,
    output logic [31:0] next_pc,
    output logic [31:0] mem_addr,
    output logic [31:0] store_data,
    output logic [3:0]  store_lanes
);

    rv_core_pkg::opcode_t  opcode;
    rv_core_pkg::alu_op_t  alu_op;
    logic [2:0]  funct3;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [31:0] alu_a, alu_b, alu_res;
    logic [31:0] pc_plus4;
    logic [7:0]  lb_byte;
    logic        taken, byte_access;

    assign opcode = rv_core_pkg::opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (funct3)
            3'b000:  taken = (rs1_val == rs2_val);
            3'b001:  taken = (rs1_val != rs2_val);
            3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
            default: taken = ($signed(rs1_val) >= $signed(rs2_val));
        endcase
    end

    always_comb begin
        iclass  = rv_core_pkg::C_ECALL; // Anything not matched below halts the core
        alu_op  = rv_core_pkg::ALU_ADD;
        alu_a   = rs1_val;
        alu_b   = imm_i;
        next_pc = pc_plus4;
        case (opcode)
            rv_core_pkg::OPC_LUI: begin
                iclass = rv_core_pkg::C_ALU;
                alu_op = rv_core_pkg::ALU_PASS_B;
                alu_b  = imm_u;
            end
            rv_core_pkg::OPC_AUIPC: begin
                iclass = rv_core_pkg::C_ALU;
                alu_a  = pc;
                alu_b  = imm_u;
            end
            rv_core_pkg::OPC_JAL: begin
                iclass  = rv_core_pkg::C_JUMP;
                next_pc = pc + imm_j;
            end
            rv_core_pkg::OPC_JALR: begin
                iclass  = rv_core_pkg::C_JUMP;
                next_pc = {alu_res[31:1], 1'b0};
            end
            rv_core_pkg::OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01 && funct3[2:1] != 2'b11) begin
                    iclass  = rv_core_pkg::C_BRANCH;
                    next_pc = taken ? pc + imm_b : pc_plus4;
                end
            end
            rv_core_pkg::OPC_LOAD: begin
                if (funct3 == 3'b000 || funct3 == 3'b010) iclass = rv_core_pkg::C_LOAD;
            end
            rv_core_pkg::OPC_STORE: begin
                alu_b = imm_s;
                if (funct3 == 3'b000 || funct3 == 3'b010) iclass = rv_core_pkg::C_STORE;
            end
            rv_core_pkg::OPC_OP_IMM, rv_core_pkg::OPC_OP: begin
                if (opcode == rv_core_pkg::OPC_OP) alu_b = rs2_val;
                iclass = rv_core_pkg::C_ALU;
                case (funct3)
                    3'b000: alu_op = (opcode == rv_core_pkg::OPC_OP && instr[30]) ?
                                     rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
                    3'b001: alu_op = rv_core_pkg::ALU_SLL;
                    3'b010: alu_op = rv_core_pkg::ALU_SLT;
                    3'b100: alu_op = rv_core_pkg::ALU_XOR;
                    3'b101: alu_op = rv_core_pkg::ALU_SRL;
                    3'b110: alu_op = rv_core_pkg::ALU_OR;
                    3'b111: alu_op = rv_core_pkg::ALU_AND;
                    default: iclass = rv_core_pkg::C_ECALL; // No unsigned compare
                endcase
                if (funct3 == 3'b101 && instr[30]) iclass = rv_core_pkg::C_ECALL; // No SRA
            end
            rv_core_pkg::OPC_SYSTEM: begin
                if (instr == rv_core_pkg::WFI_INSTR) iclass = rv_core_pkg::C_WFI;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (alu_op)
            rv_core_pkg::ALU_SUB:    alu_res = alu_a - alu_b;
            rv_core_pkg::ALU_AND:    alu_res = alu_a & alu_b;
            rv_core_pkg::ALU_OR:     alu_res = alu_a | alu_b;
            rv_core_pkg::ALU_XOR:    alu_res = alu_a ^ alu_b;
            rv_core_pkg::ALU_SLT:    alu_res = {31'd0, $signed(alu_a) < $signed(alu_b)};
            rv_core_pkg::ALU_SLL:    alu_res = alu_a << alu_b[4:0];
            rv_core_pkg::ALU_SRL:    alu_res = alu_a >> alu_b[4:0];
            rv_core_pkg::ALU_PASS_B: alu_res = alu_b;
            default:                 alu_res = alu_a + alu_b;
        endcase
    end

    assign mem_addr    = alu_res;
    assign byte_access = (funct3[1:0] == 2'b00);
    assign store_data  = byte_access ? {4{rs2_val[7:0]}} : rs2_val;
    assign store_lanes = byte_access ? (4'b0001 << mem_addr[1:0]) : 4'hf;
    assign lb_byte     = load_data[8*mem_addr[1:0] +: 8];

    always_comb begin
        case (iclass)
            rv_core_pkg::C_JUMP: wb_value = pc_plus4;
            rv_core_pkg::C_LOAD: wb_value = byte_access ? {{24{lb_byte[7]}}, lb_byte}
                                                        : load_data;
            default:             wb_value = alu_res;
        endcase
    end

endmodule

// ==== core/reg_file.sv ====
module reg_file (
    input  logic        CLK,
    input  logic        arst_n,
    input  logic        we,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [rv_core_pkg::XLEN-1:0]       wdata,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [rv_core_pkg::XLEN-1:0]       rdata1,
    output logic [rv_core_pkg::XLEN-1:0]       rdata2
);

    logic [rv_core_pkg::XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hw/irq_ctrl.sv ====
module irq_ctrl (
    input  logic        CLK,
    input  logic        arst_n,
    input  logic        ext_int,
    input  logic        ext_int_clear,
    input  logic        soft_int,
    input  logic        soft_int_clear,
    input  logic        timer_int,
    input  logic        timer_int_clear,
    input  logic [63:0] mtime,
    input  logic        mtimecmp_we,
    input  logic [31:0] mtimecmp_data,
    input  logic        irq_ack,
    output logic        irq_pending
);

    logic [31:0] mtimecmp;
    logic        ext_pend, soft_pend, timer_pend;
    logic        timer_hit;

    // Zero compare value disarms the timer
    assign timer_hit = (mtimecmp != 32'd0) && (mtime[31:0] >= mtimecmp);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            ext_pend   <= 1'b0;
            soft_pend  <= 1'b0;
            timer_pend <= 1'b0;
            mtimecmp   <= 32'd0;
        end else begin
            if (ext_int_clear || irq_ack) ext_pend <= 1'b0;
            else if (ext_int) ext_pend <= 1'b1;

            if (soft_int_clear || irq_ack) soft_pend <= 1'b0;
            else if (soft_int) soft_pend <= 1'b1;

            timer_pend <= timer_int || timer_hit; // Level, not latched

            if (timer_int_clear) mtimecmp <= 32'd0;
            else if (mtimecmp_we) mtimecmp <= mtimecmp_data;
        end
    end

    assign irq_pending = ext_pend | soft_pend | timer_pend;

    a_irq_has_source: assert property (@(posedge CLK) disable iff (!arst_n)
        $rose(irq_pending) |-> $past(ext_int || soft_int || timer_int || timer_hit));

endmodule

// ==== hw/top_core.sv ====
module top_core (
    input  logic        CLK,
    input  logic        arst_n,
    input  logic [63:0] mtime,
    output logic        wfi,
    output logic        halt,
    input  logic        busy,
    input  logic        error,
    input  logic [31:0] rdata,
    output logic        ren,
    output logic        wen,
    output logic [3:0]  byte_en,
    output logic [31:0] addr,
    output logic [31:0] wdata,
    input  logic        ext_int,
    input  logic        ext_int_clear,
    input  logic        soft_int,
    input  logic        soft_int_clear,
    input  logic        timer_int,
    input  logic        timer_int_clear
);

    logic [31:0] instr, pc, wb_value, next_pc, mem_addr;
    logic [31:0] store_data, load_data, rs1_val, rs2_val;
    logic [3:0]  store_lanes;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1, rs2, rd;
    logic        rf_we, irq_pending, irq_ack, mtimecmp_we;
    rv_core_pkg::instr_class_t iclass;

    core_ctrl u_core_ctrl (
        .CLK(CLK), .arst_n(arst_n),
        .busy(busy), .error(error), .rdata(rdata),
        .ren(ren), .wen(wen), .addr(addr), .wdata(wdata), .byte_en(byte_en),
        .instr(instr), .pc(pc), .iclass(iclass),
        .wb_value(wb_value), .next_pc(next_pc), .mem_addr(mem_addr),
        .store_data(store_data), .store_lanes(store_lanes), .load_data(load_data),
        .rf_we(rf_we), .irq_pending(irq_pending), .irq_ack(irq_ack),
        .mtimecmp_we(mtimecmp_we), .wfi(wfi), .halt(halt)
    );

    exec_unit u_exec_unit (
        .instr(instr), .pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .load_data(load_data), .rs1(rs1), .rs2(rs2), .rd(rd), .iclass(iclass),
        .wb_value(wb_value), .next_pc(next_pc), .mem_addr(mem_addr),
        .store_data(store_data), .store_lanes(store_lanes)
    );

    reg_file u_reg_file (
        .CLK(CLK), .arst_n(arst_n), .we(rf_we), .waddr(rd), .wdata(wb_value),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_val), .rdata2(rs2_val)
    );

    irq_ctrl u_irq_ctrl (
        .CLK(CLK), .arst_n(arst_n),
        .ext_int(ext_int), .ext_int_clear(ext_int_clear),
        .soft_int(soft_int), .soft_int_clear(soft_int_clear),
        .timer_int(timer_int), .timer_int_clear(timer_int_clear),
        .mtime(mtime), .mtimecmp_we(mtimecmp_we), .mtimecmp_data(store_data),
        .irq_ack(irq_ack), .irq_pending(irq_pending)
    );

endmodule

// ==== src.f ====
common/rv_core_pkg.sv
core/reg_file.sv
core/exec_unit.sv
core/core_ctrl.sv
hw/irq_ctrl.sv
hw/top_core.sv
tb/tb_mem_model.sv
tb/tb_top_core.sv

// ==== tb/tb_mem_model.sv ====
module tb_mem_model (
    input  logic        CLK,
    input  logic        arst_n,
    input  logic        stall_en,
    input  logic        ren,
    input  logic        wen,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  byte_en,
    output logic [31:0] rdata,
    output logic        busy,
    output logic        error
);

    localparam logic [31:0] ERR_ADDR = 32'h9000_0000;

    logic [31:0] mem [0:1023]; // 4 KB window, aliased over the address space
    logic [31:0] seed = 32'hb4a03fdc;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fill_pattern();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'h6b3c_0000 ^ {20'h80000, i[9:0], 2'b00};
        end
    endtask

    assign rdata = mem[addr[11:2]];
    assign error = (ren || wen) && (addr == ERR_ADDR);

    // Roughly one stall cycle in four
    always @(negedge CLK) begin
        if (!arst_n || !stall_en) begin
            busy <= 1'b0;
        end else begin
            seed = lcg_next(seed);
            busy <= (seed[31:30] == 2'b00);
        end
    end

    always @(posedge CLK) begin
        if (arst_n && wen && !busy) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) mem[addr[11:2]][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

endmodule

// ==== tb/tb_top_core.sv ====
module tb_top_core;

    logic        CLK = 1'b0;
    logic        arst_n = 1'b0;
    logic [63:0] mtime = 64'd0;
    logic        busy, error, ren, wen, wfi, halt, stall_en;
    logic [31:0] rdata, addr, wdata;
    logic [3:0]  byte_en;
    logic        ext_int, ext_int_clear, soft_int, soft_int_clear, timer_int, timer_int_clear;
    int          checks = 0;
    int          errors = 0;
    int          test_base;
    logic [31:0] prog [$];
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];
    logic [3:0]  log_be [$];
    logic [31:0] pc_a, pc_b, pc_w, ea;
    logic [7:0]  bval [4] = '{8'h81, 8'h92, 8'ha3, 8'h34};
    int          sregs [16] = '{3, 4, 5, 6, 7, 8, 9, 11, 12, 13, 14, 15, 16, 17, 18, 19};
    logic [31:0] exp_arith [16];

    top_core u_top_core (
        .CLK(CLK), .arst_n(arst_n), .mtime(mtime), .wfi(wfi), .halt(halt),
        .busy(busy), .error(error), .rdata(rdata), .ren(ren), .wen(wen),
        .byte_en(byte_en), .addr(addr), .wdata(wdata),
        .ext_int(ext_int), .ext_int_clear(ext_int_clear),
        .soft_int(soft_int), .soft_int_clear(soft_int_clear),
        .timer_int(timer_int), .timer_int_clear(timer_int_clear)
    );

    tb_mem_model u_mem (
        .CLK(CLK), .arst_n(arst_n), .stall_en(stall_en), .ren(ren), .wen(wen),
        .addr(addr), .wdata(wdata), .byte_en(byte_en), .rdata(rdata),
        .busy(busy), .error(error)
    );

    initial begin
        forever #2 CLK = ~CLK;
    end

    always @(negedge CLK) begin
        mtime <= arst_n ? mtime + 64'd1 : 64'd0;
    end

    always @(posedge CLK) begin
        if (arst_n && wen && !busy) begin // Write completes on this edge
            log_addr.push_back(addr);
            log_data.push_back(wdata);
            log_be.push_back(byte_en);
        end
    end

    a_no_overlap: assert property (@(posedge CLK) disable iff (!arst_n) !(ren && wen))
        else count_failure("Read and write requested in the same cycle");
    a_addr_hold: assert property (@(posedge CLK) disable iff (!arst_n)
        (ren || wen) && busy |=> $stable(addr))
        else count_failure("Address changed while busy was high");
    a_quiet_wfi: assert property (@(posedge CLK) (wfi || halt) |-> !(ren || wen))
        else count_failure("Bus request during wfi or halt");

    task automatic count_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction
    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction
    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction
    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
    endfunction
    function automatic logic [31:0] enc_u(int imm20, int rd, logic [6:0] op);
        return {imm20[19:0], rd[4:0], op};
    endfunction
    function automatic logic [31:0] enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] cur_pc();
        return rv_core_pkg::RESET_PC + 32'(4 * prog.size());
    endfunction

    task automatic place(input logic [31:0] base);
        foreach (prog[i]) u_mem.mem[base[11:2] + i] = prog[i];
        prog.delete();
    endtask

    // Handler stores the return address, then stops
    task automatic place_handler();
        prog.push_back(enc_s(12'h400, 31, 10, 2));
        prog.push_back(32'h0000_0073);
        place(rv_core_pkg::TRAP_VEC);
    endtask

    task automatic wait_fetch(input int limit);
        int n;
        n = 0;
        while (!ren && n < limit) begin
            @(negedge CLK);
            n++;
        end
        if (!ren) count_failure("Timeout waiting for a fetch");
    endtask

    task automatic wait_wfi(input logic level, input int limit);
        int n;
        n = 0;
        while (wfi !== level && n < limit) begin
            @(negedge CLK);
            n++;
        end
        if (wfi !== level) count_failure("Timeout waiting for wfi change");
    endtask

    task automatic wait_halt(input int limit);
        int n;
        n = 0;
        while (!halt && n < limit) begin
            @(negedge CLK);
            n++;
        end
        if (!halt) count_failure("Timeout waiting for halt");
    endtask

    task automatic start_run();
        @(negedge CLK);
        arst_n = 1'b0;
        log_addr.delete();
        log_data.delete();
        log_be.delete();
        repeat (10) begin
            @(negedge CLK);
            check_val("reset_outputs", {28'd0, ren, wen, wfi, halt}, 32'd0);
        end
        arst_n = 1'b1;
        @(negedge CLK);
        wait_fetch(20);
        check_val("addr", addr, rv_core_pkg::RESET_PC);
    endtask

    task automatic report(input string name);
        $display("test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        {ext_int, ext_int_clear, soft_int, soft_int_clear} = 4'd0;
        {timer_int, timer_int_clear, stall_en} = 3'd0;
        test_base = 0;

        // ALU, shift, compare, branch and jump results stored with SW
        u_mem.fill_pattern();
        prog.push_back(enc_u(20'h80000, 10, rv_core_pkg::OPC_LUI));
        prog.push_back(enc_i(100, 0, 0, 1, rv_core_pkg::OPC_OP_IMM));
        prog.push_back(enc_i(-7, 0, 0, 2, rv_core_pkg::OPC_OP_IMM));
        prog.push_back(enc_r(0, 2, 1, 0, 3));
        prog.push_back(enc_r(32, 1, 2, 0, 4));
        prog.push_back(enc_i(12'h055, 1, 4, 5, rv_core_pkg::OPC_OP_IMM));
        prog.push_back(enc_i(4, 1, 1, 6, rv_core_pkg::OPC_OP_IMM));
        prog.push_back(enc_i(28, 2, 5, 7, rv_core_pkg::OPC_OP_IMM));
        prog.push_back(enc_r(0, 1, 2, 2, 8));
        prog.push_back(enc_i(50, 1, 2, 9, rv_core_pkg::OPC_OP_IMM));
        prog.push_back(enc_r(0, 6, 3, 7, 11));
        prog.push_back(enc_r(0, 7, 5, 6, 12));
        prog.push_back(enc_r(0, 7, 1, 1, 13));
        prog.push_back(enc_r(0, 7, 2, 5, 14));
        prog.push_back(enc_i(12'h0f0, 2, 7, 15, rv_core_pkg::OPC_OP_IMM));
        pc_a = cur_pc();
        prog.push_back(enc_u(1, 16, rv_core_pkg::OPC_AUIPC));
        prog.push_back(enc_b(8, 0, 8, 0));
        prog.push_back(enc_i(1, 0, 0, 17, rv_core_pkg::OPC_OP_IMM));
        prog.push_back(enc_b(8, 0, 8, 1));
        prog.push_back(enc_i(16, 17, 0, 17, rv_core_pkg::OPC_OP_IMM));
        prog.push_back(enc_b(8, 1, 2, 4));
        prog.push_back(enc_i(32, 17, 0, 17, rv_core_pkg::OPC_OP_IMM));
        prog.push_back(enc_b(8, 1, 2, 5));
        prog.push_back(enc_i(4, 17, 0, 17, rv_core_pkg::OPC_OP_IMM));
        pc_w = cur_pc();
        prog.push_back(enc_j(8, 18));
        prog.push_back(enc_i(64, 17, 0, 17, rv_core_pkg::OPC_OP_IMM));
        pc_b = cur_pc();
        prog.push_back(enc_u(0, 20, rv_core_pkg::OPC_AUIPC));
        prog.push_back(enc_i(12, 20, 0, 19, rv_core_pkg::OPC_JALR));
        prog.push_back(enc_i(128, 17, 0, 17, rv_core_pkg::OPC_OP_IMM));
        foreach (sregs[k]) prog.push_back(enc_s(12'h200 + 4 * k, sregs[k], 10, 2));
        prog.push_back(32'h0000_0073);
        place(rv_core_pkg::RESET_PC);
        exp_arith = '{32'd93, 32'hffff_ff95, 32'h31, 32'h640, 32'hf, 32'd1, 32'd0,
                      32'd93 & 32'h640, 32'h31 | 32'hf, 32'd100 << 15, 32'hffff_fff9 >> 15,
                      32'hf0, pc_a + 32'h1000, 32'd5, pc_w + 32'd4, pc_b + 32'd8};
        stall_en = 1'b1;
        start_run();
        report("reset");
        wait_halt(2000);
        check_val("log_size", log_addr.size(), 32'd16);
        for (int k = 0; k < 16 && k < log_addr.size(); k++) begin
            check_val("addr", log_addr[k], 32'h8000_0200 + 32'(4 * k));
            check_val("wdata", log_data[k], exp_arith[k]);
        end
        report("arith");

        // SB to each lane, then LB back and SW the sign-extended value
        u_mem.fill_pattern();
        prog.push_back(enc_u(20'h80000, 10, rv_core_pkg::OPC_LUI));
        for (int k = 0; k < 4; k++) begin
            prog.push_back(enc_i(bval[k], 0, 0, 1, rv_core_pkg::OPC_OP_IMM));
            prog.push_back(enc_s(12'h300 + k, 1, 10, 0));
        end
        for (int k = 0; k < 4; k++) begin
            prog.push_back(enc_i(12'h300 + k, 10, 0, 2, rv_core_pkg::OPC_LOAD));
            prog.push_back(enc_s(12'h310 + 4 * k, 2, 10, 2));
        end
        prog.push_back(32'h0000_0073);
        place(rv_core_pkg::RESET_PC);
        start_run();
        wait_halt(2000);
        check_val("log_size", log_addr.size(), 32'd8);
        for (int k = 0; k < 4 && log_addr.size() == 8; k++) begin
            check_val("addr", log_addr[k], 32'h8000_0300 + k);
            check_val("byte_en", log_be[k], 4'b0001 << k);
            check_val("wdata", log_data[k][8*k +: 8], bval[k]);
            check_val("wdata", log_data[4+k], {{24{bval[k][7]}}, bval[k]});
        end
        report("bytes");

        // WFI woken by the external interrupt
        u_mem.fill_pattern();
        prog.push_back(enc_u(20'h80000, 10, rv_core_pkg::OPC_LUI));
        prog.push_back(enc_i(7, 0, 0, 1, rv_core_pkg::OPC_OP_IMM));
        pc_w = cur_pc();
        prog.push_back(32'h1050_0073);
        prog.push_back(32'h0000_0073);
        place(rv_core_pkg::RESET_PC);
        place_handler();
        start_run();
        wait_wfi(1'b1, 200);
        repeat (20) begin
            @(negedge CLK);
            check_val("wfi", wfi, 1'b1);
        end
        ext_int = 1'b1;
        wait_wfi(1'b0, 20);
        ext_int = 1'b0;
        wait_fetch(20);
        check_val("addr", addr, rv_core_pkg::TRAP_VEC);
        wait_halt(200);
        check_val("log_size", log_addr.size(), 32'd1);
        if (log_addr.size() == 1) begin
            check_val("addr", log_addr[0], 32'h8000_0400);
            check_val("wdata", log_data[0], pc_w + 32'd4);
        end
        report("wfi");

        // Timer compare written by a store, then WFI until mtime reaches it
        u_mem.fill_pattern();
        prog.push_back(enc_u(20'h80000, 10, rv_core_pkg::OPC_LUI));
        prog.push_back(enc_u(20'hf0000, 11, rv_core_pkg::OPC_LUI));
        prog.push_back(enc_i(200, 0, 0, 12, rv_core_pkg::OPC_OP_IMM));
        prog.push_back(enc_s(0, 12, 11, 2));
        pc_w = cur_pc();
        prog.push_back(32'h1050_0073);
        prog.push_back(32'h0000_0073);
        place(rv_core_pkg::RESET_PC);
        place_handler();
        start_run();
        wait_wfi(1'b1, 150);
        check_val("mtime_below_cmp", mtime < 64'd200, 1'b1);
        wait_wfi(1'b0, 400);
        check_val("mtime_at_cmp", mtime >= 64'd200, 1'b1);
        timer_int_clear = 1'b1;
        @(negedge CLK);
        timer_int_clear = 1'b0;
        wait_halt(200);
        foreach (log_addr[k]) check_val("addr_not_mtimecmp", log_addr[k] == ea, 1'b0);
        check_val("log_size", log_addr.size(), 32'd1);
        if (log_addr.size() == 1) check_val("wdata", log_data[0], pc_w + 32'd4);
        report("timer");

        // Load from the error address must halt before the following store
        u_mem.fill_pattern();
        prog.push_back(enc_u(20'h90000, 10, rv_core_pkg::OPC_LUI));
        prog.push_back(enc_u(20'h80000, 11, rv_core_pkg::OPC_LUI));
        prog.push_back(enc_i(0, 10, 2, 1, rv_core_pkg::OPC_LOAD));
        prog.push_back(enc_s(12'h500, 1, 11, 2));
        prog.push_back(32'h0000_0073);
        place(rv_core_pkg::RESET_PC);
        start_run();
        wait_halt(200);
        repeat (10) @(negedge CLK);
        check_val("halt", halt, 1'b1);
        check_val("log_size", log_addr.size(), 32'd0);
        report("halt");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial ea = rv_core_pkg::MTIMECMP_ADDR;

endmodule
